// File: common/mem_settings.svh
// ====================
// Memory subsystem settings
// Sizes, widths and the address map
// ====================
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Core-side bus widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32

// Data RAM, 16 KiB of 32-bit words
`define MEM_DEPTH 4096
`define MEM_INDEX_WIDTH 12

// APB port towards the debug module
`define MEM_APB_ADDR_WIDTH 13

// Debug area, inclusive byte range, only decoded in debug mode
`define MEM_DEBUG_BASE 32'h0000_0800
`define MEM_DEBUG_END 32'h0000_0FFF

// Test-result word
`define MEM_TOHOST_ADDR 32'h0000_3FF0

// RAM power-up content, addi x0, x0, 0
`define MEM_FILL_WORD 32'h0000_0013

`endif

// File: common/mem_pkg.sv
// ====================
// Memory subsystem types
// ====================
`include "mem_settings.svh"

package mem_pkg;

  // Byte address as issued by the core
  typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

  // One data word
  typedef logic [`MEM_DATA_WIDTH-1:0] word_t;

  // RAM word index, byte address bits 13 down to 2
  typedef logic [`MEM_INDEX_WIDTH-1:0] word_index_t;

  // APB address, low bits of the byte address
  typedef logic [`MEM_APB_ADDR_WIDTH-1:0] apb_addr_t;

  // APB master phases
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_t;

endpackage

// File: design/memory/data_bram.sv
// ====================
// Data RAM
// Single port, write on the edge, registered read
// ====================
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_bram (
  input  logic                  clk,
  input  logic                  i_read,
  input  logic                  i_write,
  input  mem_pkg::word_index_t  i_index,
  input  mem_pkg::word_t        i_wdata,
  output mem_pkg::word_t        o_rdata
);

  import mem_pkg::*;

  word_t mem [`MEM_DEPTH];

  // Every word starts out as a NOP
  initial
  begin
    for (int i = 0; i < `MEM_DEPTH; i++)
    begin
      mem[i] = `MEM_FILL_WORD;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_write)
    begin
      mem[i_index] <= i_wdata;
    end
  end

  // Read data shows up in the cycle after the request
  always_ff @(posedge clk)
  begin
    if (i_read)
    begin
      o_rdata <= mem[i_index];
    end
  end

  // The router must never issue both on the single port
  a_no_read_write: assert property (
    @(posedge clk) !(i_read && i_write)
  ) else $error("data_bram: read and write in the same cycle");

endmodule

// File: design/apb_bridge/apb_master_fsm.sv
// ====================
// APB master for debug-area accesses
// Runs one captured read or write at a time
// ====================
`timescale 1ns/1ps

module apb_master_fsm (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                i_start,
  input  logic                i_write,
  input  mem_pkg::apb_addr_t  i_addr,
  input  mem_pkg::word_t      i_wdata,
  input  logic                i_apb_pready,
  input  mem_pkg::word_t      i_apb_prdata,
  input  logic                i_apb_pslverr,
  output logic                o_idle,
  output logic                o_rsp_valid,
  output mem_pkg::word_t      o_rdata,
  output logic                o_error,
  output mem_pkg::apb_addr_t  o_apb_paddr,
  output logic                o_apb_psel,
  output logic                o_apb_penable,
  output logic                o_apb_pwrite,
  output mem_pkg::word_t      o_apb_pwdata
);

  import mem_pkg::*;

  apb_state_t state;
  apb_state_t state_next;
  logic       write_q;
  apb_addr_t  addr_q;
  word_t      wdata_q;

  // ====================
  // Phase sequencing
  // ====================
  always_comb
  begin
    state_next = state;
    case (state)
      APB_IDLE:
        if (i_start)
          state_next = APB_SETUP;
      APB_SETUP:
        state_next = APB_ACCESS;
      APB_ACCESS:
        if (i_apb_pready)
          state_next = APB_IDLE;
      default:
        state_next = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state   <= APB_IDLE;
      write_q <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (i_start && state == APB_IDLE)
        write_q <= i_write;
    end
  end

  // Address and data held for the whole transfer
  always_ff @(posedge clk)
  begin
    if (i_start && state == APB_IDLE)
    begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
    end
  end

  // ====================
  // Bus and response outputs
  // ====================
  assign o_apb_psel    = (state != APB_IDLE);
  assign o_apb_penable = (state == APB_ACCESS);
  assign o_apb_paddr   = addr_q;
  assign o_apb_pwrite  = write_q;
  assign o_apb_pwdata  = wdata_q;

  assign o_idle = (state == APB_IDLE);

  // Only reads report back, in the cycle the slave completes
  assign o_rsp_valid = (state == APB_ACCESS) && i_apb_pready && !write_q;
  assign o_rdata     = i_apb_prdata;
  assign o_error     = i_apb_pslverr;

  // Access phase always follows a selected setup cycle
  a_penable_after_setup: assert property (
    @(posedge clk) disable iff (!reset_n)
    o_apb_penable |-> o_apb_psel && $past(o_apb_psel)
  ) else $error("apb_master_fsm: penable without a preceding setup");

  // Router holds off new debug accesses while a transfer runs
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!reset_n)
    i_start |-> o_idle
  ) else $error("apb_master_fsm: start while busy");

endmodule

// File: design/mem_request_router.sv
// ====================
// Request router
// Splits core accesses between RAM and APB, merges replies
// ====================
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_request_router (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_debug_mode,
  input  logic                  i_req_valid,
  input  logic                  i_req_write,
  input  mem_pkg::addr_t        i_req_addr,
  input  mem_pkg::word_t        i_req_wdata,
  input  mem_pkg::word_t        i_ram_rdata,
  input  logic                  i_dbg_idle,
  input  logic                  i_dbg_rsp_valid,
  input  mem_pkg::word_t        i_dbg_rdata,
  input  logic                  i_dbg_error,
  output logic                  o_req_ready,
  output logic                  o_rsp_valid,
  output mem_pkg::word_t        o_rsp_rdata,
  output logic                  o_rsp_error,
  output logic                  o_ram_read,
  output logic                  o_ram_write,
  output mem_pkg::word_index_t  o_ram_index,
  output mem_pkg::word_t        o_ram_wdata,
  output logic                  o_dbg_start,
  output logic                  o_dbg_write,
  output mem_pkg::apb_addr_t    o_dbg_addr,
  output mem_pkg::word_t        o_dbg_wdata,
  output mem_pkg::word_t        o_tohost
);

  import mem_pkg::*;

  logic  accept;
  logic  is_debug;
  logic  ram_pending;
  word_t tohost_q;

  // ====================
  // Decode and dispatch
  // ====================

  // Nothing is taken while the APB master is busy
  assign o_req_ready = i_dbg_idle;
  assign accept      = i_req_valid && o_req_ready;

  // The debug area only exists while the hart is halted in debug mode
  assign is_debug = i_debug_mode &&
                    (i_req_addr >= `MEM_DEBUG_BASE) &&
                    (i_req_addr <= `MEM_DEBUG_END);

  assign o_ram_read  = accept && !is_debug && !i_req_write;
  assign o_ram_write = accept && !is_debug && i_req_write;
  assign o_ram_index = i_req_addr[`MEM_INDEX_WIDTH+1:2];
  assign o_ram_wdata = i_req_wdata;

  assign o_dbg_start = accept && is_debug;
  assign o_dbg_write = i_req_write;
  assign o_dbg_addr  = i_req_addr[`MEM_APB_ADDR_WIDTH-1:0];
  assign o_dbg_wdata = i_req_wdata;

  // ====================
  // Response merge
  // ====================

  // RAM data is one cycle behind the accepted read
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ram_pending <= 1'b0;
    else
      ram_pending <= o_ram_read;
  end

  assign o_rsp_valid = ram_pending || i_dbg_rsp_valid;
  assign o_rsp_rdata = ram_pending ? i_ram_rdata : i_dbg_rdata;
  assign o_rsp_error = ram_pending ? 1'b0 : i_dbg_error;

  // Test-result capture, seen on every accepted write to the word
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      tohost_q <= '0;
    else if (accept && i_req_write && i_req_addr == `MEM_TOHOST_ADDR)
      tohost_q <= i_req_wdata;
  end

  assign o_tohost = tohost_q;

  // A debug read cannot finish before an earlier RAM read has answered
  a_single_response: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(ram_pending && i_dbg_rsp_valid)
  ) else $error("mem_request_router: RAM and debug response collide");

endmodule

// File: design/mem_subsystem.sv
// ====================
// Data memory subsystem top
// ====================
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                i_debug_mode,
  input  logic                i_req_valid,
  input  logic                i_req_write,
  input  mem_pkg::addr_t      i_req_addr,
  input  mem_pkg::word_t      i_req_wdata,
  input  logic                i_apb_pready,
  input  mem_pkg::word_t      i_apb_prdata,
  input  logic                i_apb_pslverr,
  output logic                o_req_ready,
  output logic                o_rsp_valid,
  output mem_pkg::word_t      o_rsp_rdata,
  output logic                o_rsp_error,
  output mem_pkg::word_t      o_tohost,
  output mem_pkg::apb_addr_t  o_apb_paddr,
  output logic                o_apb_psel,
  output logic                o_apb_penable,
  output logic                o_apb_pwrite,
  output mem_pkg::word_t      o_apb_pwdata
);

  import mem_pkg::*;

  // RAM port
  logic        ram_read;
  logic        ram_write;
  word_index_t ram_index;
  word_t       ram_wdata;
  word_t       ram_rdata;

  // Router to APB master
  logic      dbg_start;
  logic      dbg_write;
  apb_addr_t dbg_addr;
  word_t     dbg_wdata;
  logic      dbg_idle;
  logic      dbg_rsp_valid;
  word_t     dbg_rdata;
  logic      dbg_error;

  mem_request_router u_router (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_debug_mode    (i_debug_mode),
    .i_req_valid     (i_req_valid),
    .i_req_write     (i_req_write),
    .i_req_addr      (i_req_addr),
    .i_req_wdata     (i_req_wdata),
    .i_ram_rdata     (ram_rdata),
    .i_dbg_idle      (dbg_idle),
    .i_dbg_rsp_valid (dbg_rsp_valid),
    .i_dbg_rdata     (dbg_rdata),
    .i_dbg_error     (dbg_error),
    .o_req_ready     (o_req_ready),
    .o_rsp_valid     (o_rsp_valid),
    .o_rsp_rdata     (o_rsp_rdata),
    .o_rsp_error     (o_rsp_error),
    .o_ram_read      (ram_read),
    .o_ram_write     (ram_write),
    .o_ram_index     (ram_index),
    .o_ram_wdata     (ram_wdata),
    .o_dbg_start     (dbg_start),
    .o_dbg_write     (dbg_write),
    .o_dbg_addr      (dbg_addr),
    .o_dbg_wdata     (dbg_wdata),
    .o_tohost        (o_tohost)
  );

  data_bram u_ram (
    .clk     (clk),
    .i_read  (ram_read),
    .i_write (ram_write),
    .i_index (ram_index),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

  apb_master_fsm u_apb (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_start       (dbg_start),
    .i_write       (dbg_write),
    .i_addr        (dbg_addr),
    .i_wdata       (dbg_wdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .i_apb_pslverr (i_apb_pslverr),
    .o_idle        (dbg_idle),
    .o_rsp_valid   (dbg_rsp_valid),
    .o_rdata       (dbg_rdata),
    .o_error       (dbg_error),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata)
  );

endmodule

// File: testbench/apb_debug_responder.sv
// ====================
// Debug module APB slave model
// Random wait states, address-derived read data, write reporting
// ====================
`timescale 1ns/1ps

module apb_debug_responder (
  input  logic                clk,
  input  logic                reset_n,
  input  mem_pkg::apb_addr_t  i_paddr,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  mem_pkg::word_t      i_pwdata,
  output logic                o_pready,
  output mem_pkg::word_t      o_prdata,
  output logic                o_pslverr,
  output logic                o_wr_valid,
  output mem_pkg::apb_addr_t  o_wr_addr,
  output mem_pkg::word_t      o_wr_data
);

  import mem_pkg::*;

  integer     seed = 32'h85d3;
  logic [1:0] wait_cnt;

  // Zero to three wait states, drawn when the setup cycle ends
  always @(posedge clk or negedge reset_n)
  begin : wait_gen
    logic [1:0] pick;
    if (!reset_n)
    begin
      o_pready <= 1'b0;
      wait_cnt <= 2'd0;
    end
    else if (i_psel && !i_penable)
    begin
      pick = 2'($random(seed));
      wait_cnt <= pick;
      o_pready <= (pick == 2'd0);
    end
    else if (i_psel && i_penable)
    begin
      if (o_pready)
        o_pready <= 1'b0;
      else if (wait_cnt == 2'd1)
      begin
        o_pready <= 1'b1;
        wait_cnt <= 2'd0;
      end
      else
        wait_cnt <= wait_cnt - 2'd1;
    end
  end

  assign o_prdata  = {19'd0, i_paddr} ^ 32'hDB60_0000;
  assign o_pslverr = (i_paddr == 13'h0FFC);

  // Completed writes, one entry per transfer
  assign o_wr_valid = i_psel && i_penable && o_pready && i_pwrite;
  assign o_wr_addr  = i_paddr;
  assign o_wr_data  = i_pwdata;

endmodule

// File: testbench/mem_subsystem_tb.sv
// ====================
// Memory subsystem testbench
// Random RAM, debug and tohost traffic against a reference model
// ====================
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_tb;

  import mem_pkg::*;

  localparam int NUM_REQUESTS = 600;
  localparam int MAX_CYCLES   = NUM_REQUESTS * 12;

  logic      clk;
  logic      reset_n;
  logic      debug_mode;
  logic      req_valid;
  logic      req_write;
  addr_t     req_addr;
  word_t     req_wdata;
  logic      req_ready;
  logic      rsp_valid;
  word_t     rsp_rdata;
  logic      rsp_error;
  word_t     tohost;
  apb_addr_t apb_paddr;
  logic      apb_psel;
  logic      apb_penable;
  logic      apb_pwrite;
  word_t     apb_pwdata;
  logic      apb_pready;
  word_t     apb_prdata;
  logic      apb_pslverr;
  logic      wr_valid;
  apb_addr_t wr_addr;
  word_t     wr_data;

  integer seed;
  int     mismatch_count = 0;
  int     other_count = 0;
  int     cycle_count = 0;

  // Reference model
  word_t     model_mem [`MEM_DEPTH];
  word_t     model_tohost;
  word_t     exp_rdata_q [$];
  logic      exp_error_q [$];
  apb_addr_t exp_wr_addr_q [$];
  word_t     exp_wr_data_q [$];
  logic      ram_due;
  logic      dbg_busy;
  logic      dbg_read;
  logic      dbg_done;
  logic      reset_checked;

  mem_subsystem dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (debug_mode),
    .i_req_valid   (req_valid),
    .i_req_write   (req_write),
    .i_req_addr    (req_addr),
    .i_req_wdata   (req_wdata),
    .i_apb_pready  (apb_pready),
    .i_apb_prdata  (apb_prdata),
    .i_apb_pslverr (apb_pslverr),
    .o_req_ready   (req_ready),
    .o_rsp_valid   (rsp_valid),
    .o_rsp_rdata   (rsp_rdata),
    .o_rsp_error   (rsp_error),
    .o_tohost      (tohost),
    .o_apb_paddr   (apb_paddr),
    .o_apb_psel    (apb_psel),
    .o_apb_penable (apb_penable),
    .o_apb_pwrite  (apb_pwrite),
    .o_apb_pwdata  (apb_pwdata)
  );

  apb_debug_responder u_responder (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_paddr    (apb_paddr),
    .i_psel     (apb_psel),
    .i_penable  (apb_penable),
    .i_pwrite   (apb_pwrite),
    .i_pwdata   (apb_pwdata),
    .o_pready   (apb_pready),
    .o_prdata   (apb_prdata),
    .o_pslverr  (apb_pslverr),
    .o_wr_valid (wr_valid),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_equal(input string what, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      mismatch_count++;
    end
  endtask

  // ====================
  // Monitor and model
  // ====================

  // Sampled mid-cycle, away from the edge where inputs change
  always @(negedge clk)
  begin : monitor
    logic is_dbg;
    if (!reset_n)
    begin
      for (int i = 0; i < `MEM_DEPTH; i++)
        model_mem[i] = `MEM_FILL_WORD;
      model_tohost  = '0;
      ram_due       = 1'b0;
      dbg_busy      = 1'b0;
      dbg_read      = 1'b0;
      dbg_done      = 1'b0;
      reset_checked = 1'b0;
    end
    else
    begin
      if (!reset_checked)
      begin
        check_equal("ready after reset", 32'(req_ready), 32'd1);
        check_equal("rsp_valid after reset", 32'(rsp_valid), 32'd0);
        check_equal("psel after reset", 32'(apb_psel), 32'd0);
        reset_checked = 1'b1;
      end
      // Ready comes back in the cycle after the APB access ends
      if (dbg_done)
        check_equal("ready after debug access", 32'(req_ready), 32'd1);
      dbg_done = 1'b0;
      if (ram_due && !rsp_valid)
      begin
        $display("At %0t ns a RAM read got no response in the following cycle", $time);
        other_count++;
      end
      ram_due = 1'b0;
      if (rsp_valid)
      begin
        if (exp_rdata_q.size() == 0)
        begin
          $display("At %0t ns a response came with no read outstanding", $time);
          other_count++;
        end
        else
        begin
          check_equal("read data", rsp_rdata, exp_rdata_q.pop_front());
          check_equal("read error", 32'(rsp_error), 32'(exp_error_q.pop_front()));
        end
      end
      if (wr_valid)
      begin
        if (exp_wr_addr_q.size() == 0)
        begin
          $display("At %0t ns the debug module saw a write that was never issued", $time);
          other_count++;
        end
        else
        begin
          check_equal("debug write address", 32'(wr_addr), 32'(exp_wr_addr_q.pop_front()));
          check_equal("debug write data", wr_data, exp_wr_data_q.pop_front());
        end
      end
      if (dbg_busy)
        check_equal("ready during debug access", 32'(req_ready), 32'd0);
      if (apb_psel && !dbg_busy)
      begin
        $display("At %0t ns psel is high with no debug access accepted", $time);
        other_count++;
      end
      // A debug read answers in the cycle the slave completes, a write never does
      if (dbg_busy && apb_penable && apb_pready)
      begin
        check_equal("debug read response on completion", 32'(rsp_valid), 32'(dbg_read));
        dbg_busy = 1'b0;
        dbg_done = 1'b1;
      end
      check_equal("tohost", tohost, model_tohost);

      // Request that transfers at the coming edge
      if (req_valid && req_ready)
      begin
        is_dbg = debug_mode && req_addr >= `MEM_DEBUG_BASE && req_addr <= `MEM_DEBUG_END;
        if (is_dbg)
        begin
          dbg_busy = 1'b1;
          dbg_read = !req_write;
          if (req_write)
          begin
            exp_wr_addr_q.push_back(req_addr[12:0]);
            exp_wr_data_q.push_back(req_wdata);
          end
          else
          begin
            exp_rdata_q.push_back({19'd0, req_addr[12:0]} ^ 32'hDB60_0000);
            exp_error_q.push_back(req_addr == 32'h0000_0FFC);
          end
        end
        else if (req_write)
          model_mem[req_addr[13:2]] = req_wdata;
        else
        begin
          exp_rdata_q.push_back(model_mem[req_addr[13:2]]);
          exp_error_q.push_back(1'b0);
          ram_due = 1'b1;
        end
        if (req_write && req_addr == `MEM_TOHOST_ADDR)
          model_tohost = req_wdata;
      end
    end
  end

  // ====================
  // Stimulus
  // ====================
  task automatic send_request();
    logic [2:0] kind;
    addr_t      addr;
    kind = 3'($random(seed));
    case (kind)
      3'd4, 3'd5: addr = `MEM_DEBUG_BASE | {21'd0, 9'($random(seed)), 2'b00};
      3'd6:       addr = 32'h0000_0FFC;
      3'd7:       addr = `MEM_TOHOST_ADDR;
      default:    addr = {18'd0, 12'($random(seed)), 2'b00};
    endcase
    // Occasional idle cycle between requests
    if (2'($random(seed)) == 2'd0)
    begin
      req_valid <= 1'b0;
      @(posedge clk);
    end
    req_valid <= 1'b1;
    req_write <= 1'($random(seed));
    req_addr  <= addr;
    req_wdata <= $random(seed);
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    @(posedge clk);
  endtask

  task automatic drain_requests();
    req_valid <= 1'b0;
    @(negedge clk);
    while (!req_ready || dbg_busy)
      @(negedge clk);
    @(posedge clk);
  endtask

  initial
  begin
    int issued;
    int phase_len;
    int leftover;
    seed        = 32'h85d3;
    reset_n     = 1'b0;
    debug_mode  = 1'b0;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    issued = 0;
    while (issued < NUM_REQUESTS)
    begin
      phase_len = 50 + int'(6'($random(seed)));
      for (int n = 0; n < phase_len && issued < NUM_REQUESTS; n++)
      begin
        send_request();
        issued++;
      end
      drain_requests();
      debug_mode <= !debug_mode;
    end
    repeat (4) @(posedge clk);
    leftover = exp_rdata_q.size() + exp_wr_addr_q.size();
    if (leftover != 0)
      $display("%0d expected read responses or debug writes never arrived", leftover);
    $display("Errors: %0d value mismatches, %0d other failures, %0d missing",
             mismatch_count, other_count, leftover);
    if (mismatch_count == 0 && other_count == 0 && leftover == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Bound on the whole run
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d value mismatches, %0d other failures",
               mismatch_count, other_count);
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

// File: files.f
+incdir+common
common/mem_pkg.sv
design/memory/data_bram.sv
design/apb_bridge/apb_master_fsm.sv
design/mem_request_router.sv
design/mem_subsystem.sv
testbench/apb_debug_responder.sv
testbench/mem_subsystem_tb.sv

// File: Makefile
# Verilator build for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
